/* sources.f */
+incdir+hw
hw/cdc_pkg.sv
hw/cdc_clear_if.sv
hw/cdc_sync.sv
hw/cdc_src_half.sv
hw/cdc_dst_half.sv
hw/cdc_clear_ctrl.sv
hw/cdc_bridge_top.sv
test/tb_cdc_bridge.sv

/* test/tb_cdc_bridge.sv */
// cdc bridge testbench, which runs a table of sends, clears and resets through two clock domains
`include "cdc_consts.svh"

module tb_cdc_bridge import cdc_pkg::*; ;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PAYLOAD_W   = `CDC_TAG_W + `CDC_DATA_W;
  localparam int SRC_HALF_NS = 20;
  localparam int DST_HALF_NS = 28;
  localparam int TIMEOUT     = 200;
  // long enough for an item to reach the destination while it is stalled
  localparam int HOLD_CYCLES = 20;
  localparam int SEED        = 76756;
  localparam int NUM_STEPS   = 14;

  typedef enum {OP_SEND, OP_BACKPRESSURE, OP_SRC_CLEAR, OP_DST_CLEAR, OP_SRC_RESET} op_e;

  // one table row, the tag and data fields form the payload of send operations
  typedef struct {
    op_e                    op;
    logic [`CDC_TAG_W-1:0]  tag;
    logic [`CDC_DATA_W-1:0] data;
  } step_t;

  logic                 src_clk_i;
  logic                 src_rst_ni;
  logic                 src_clear_i;
  logic                 src_valid_i;
  logic [PAYLOAD_W-1:0] src_data_i;
  logic                 src_ready_o;
  logic                 src_clear_pending_o;
  logic                 dst_clk_i;
  logic                 dst_rst_ni;
  logic                 dst_clear_i;
  logic                 dst_ready_i;
  logic [PAYLOAD_W-1:0] dst_data_o;
  logic                 dst_valid_o;
  logic                 dst_clear_pending_o;

  // items accepted at the source and not yet taken at the destination
  payload_t expected_q[$];
  logic     hold_dst_low;

  // every clear or reset step comes after an odd number of items,
  // so both toggles are high when the sequence starts
  step_t steps [NUM_STEPS] = '{
    '{OP_SEND,         4'h1, 28'h0000001},
    '{OP_SEND,         4'h2, 28'hABCDEF0},
    '{OP_SEND,         4'hF, 28'hFFFFFFF},
    '{OP_BACKPRESSURE, 4'h5, 28'h5A5A5A5},
    '{OP_SRC_CLEAR,    4'h0, 28'h0000000},
    '{OP_SEND,         4'h3, 28'h1234567},
    '{OP_DST_CLEAR,    4'h0, 28'h0000000},
    '{OP_SEND,         4'h0, 28'h0000000},
    '{OP_SEND,         4'h7, 28'h7654321},
    '{OP_SEND,         4'h8, 28'h8000008},
    '{OP_SRC_RESET,    4'h0, 28'h0000000},
    '{OP_SEND,         4'hC, 28'hC0FFEE1},
    '{OP_BACKPRESSURE, 4'h9, 28'h0F0F0F0},
    '{OP_SEND,         4'hA, 28'hAAAAAAA}
  };

  cdc_bridge_top i_cdc_bridge_top (
    .src_clk_i           (src_clk_i),
    .src_rst_ni          (src_rst_ni),
    .src_clear_i         (src_clear_i),
    .src_valid_i         (src_valid_i),
    .src_data_i          (src_data_i),
    .src_ready_o         (src_ready_o),
    .src_clear_pending_o (src_clear_pending_o),
    .dst_clk_i           (dst_clk_i),
    .dst_rst_ni          (dst_rst_ni),
    .dst_clear_i         (dst_clear_i),
    .dst_ready_i         (dst_ready_i),
    .dst_data_o          (dst_data_o),
    .dst_valid_o         (dst_valid_o),
    .dst_clear_pending_o (dst_clear_pending_o)
  );

  initial begin
    src_clk_i = 1'b0;
    forever #(SRC_HALF_NS) src_clk_i = ~src_clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #(DST_HALF_NS) dst_clk_i = ~dst_clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // the consumer stalls at random unless a test holds it low
  always @(posedge dst_clk_i) begin
    if (hold_dst_low) begin
      dst_ready_i <= 1'b0;
    end else begin
      dst_ready_i <= ($urandom_range(3) != 0);
    end
  end

  // inputs only move on rising edges, so the negative edge sees the handshake
  // that the next rising edge will complete
  always @(negedge dst_clk_i) begin
    if (dst_valid_o === 1'b1 && dst_ready_i === 1'b1) begin
      if (expected_q.size() == 0) begin
        stop_on_error("an item appeared at the destination that was never sent");
      end else begin
        check_value("dst_data_o", dst_data_o, expected_q.pop_front());
      end
    end
  end

  task automatic drive_item(input payload_t item);
    @(posedge src_clk_i);
    src_valid_i <= 1'b1;
    src_data_i  <= item;
  endtask

  // keeps valid up until the source takes the item, then drops it
  task automatic await_accept(input payload_t item);
    int cycles;
    cycles = 0;
    @(negedge src_clk_i);
    while (src_ready_o !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error("source never became ready to accept an item");
      end
      @(negedge src_clk_i);
    end
    expected_q.push_back(item);
    @(posedge src_clk_i);
    src_valid_i <= 1'b0;
  endtask

  // every item sent so far has been taken and the source is free again
  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    @(negedge src_clk_i);
    while (expected_q.size() != 0 || src_ready_o !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error("items were still in flight after the timeout");
      end
      @(negedge src_clk_i);
    end
  endtask

  // the source stays masked for as long as its clear is pending
  task automatic follow_src_pending(input logic level);
    int cycles;
    cycles = 0;
    @(negedge src_clk_i);
    while (src_clear_pending_o !== level) begin
      if (src_clear_pending_o === 1'b1) begin
        check_value("src_ready_o", src_ready_o, 1'b0);
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error($sformatf("src_clear_pending_o did not go to %0d in time", level));
      end
      @(negedge src_clk_i);
    end
  endtask

  task automatic follow_dst_pending(input logic level);
    int cycles;
    cycles = 0;
    @(negedge dst_clk_i);
    while (dst_clear_pending_o !== level) begin
      if (dst_clear_pending_o === 1'b1) begin
        check_value("dst_valid_o", dst_valid_o, 1'b0);
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error($sformatf("dst_clear_pending_o did not go to %0d in time", level));
      end
      @(negedge dst_clk_i);
    end
  endtask

  task automatic pulse_src_clear();
    @(posedge src_clk_i);
    src_clear_i <= 1'b1;
    @(posedge src_clk_i);
    src_clear_i <= 1'b0;
    // the requesting side is isolated one cycle after the request
    @(negedge src_clk_i);
    check_value("src_clear_pending_o", src_clear_pending_o, 1'b1);
    check_value("src_ready_o", src_ready_o, 1'b0);
    follow_dst_pending(1'b1);
    follow_src_pending(1'b0);
    follow_dst_pending(1'b0);
  endtask

  task automatic pulse_dst_clear();
    @(posedge dst_clk_i);
    dst_clear_i <= 1'b1;
    @(posedge dst_clk_i);
    dst_clear_i <= 1'b0;
    @(negedge dst_clk_i);
    check_value("dst_clear_pending_o", dst_clear_pending_o, 1'b1);
    check_value("dst_valid_o", dst_valid_o, 1'b0);
    follow_src_pending(1'b1);
    follow_dst_pending(1'b0);
    follow_src_pending(1'b0);
  endtask

  // a reset of the source alone must pull the destination into a clear
  task automatic pulse_src_reset();
    @(posedge src_clk_i);
    src_rst_ni <= 1'b0;
    repeat (2) @(posedge src_clk_i);
    src_rst_ni <= 1'b1;
    follow_dst_pending(1'b1);
    follow_dst_pending(1'b0);
    follow_src_pending(1'b0);
  endtask

  // the second item is the bitwise inverse of the first
  task automatic run_backpressure(input payload_t first);
    payload_t second;
    int       cycles;
    second       = ~first;
    hold_dst_low = 1'b1;
    cycles       = 0;
    @(negedge dst_clk_i);
    while (dst_ready_i !== 1'b0) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error("dst_ready_i could not be held low");
      end
      @(negedge dst_clk_i);
    end
    drive_item(first);
    await_accept(first);
    drive_item(second);
    repeat (HOLD_CYCLES) begin
      @(negedge src_clk_i);
      check_value("src_ready_o", src_ready_o, 1'b0);
    end
    @(negedge dst_clk_i);
    check_value("dst_valid_o", dst_valid_o, 1'b1);
    // the stalled item at the output is still the first one
    check_value("dst_data_o", dst_data_o, first);
    hold_dst_low = 1'b0;
    await_accept(second);
  endtask

  initial begin
    payload_t item;
    void'($urandom(SEED));
    src_rst_ni   = 1'b0;
    dst_rst_ni   = 1'b0;
    src_clear_i  = 1'b0;
    src_valid_i  = 1'b0;
    src_data_i   = '0;
    dst_clear_i  = 1'b0;
    dst_ready_i  = 1'b0;
    hold_dst_low = 1'b0;

    // each side leaves reset after two cycles of its own clock
    fork
      begin
        repeat (2) @(posedge src_clk_i);
        src_rst_ni <= 1'b1;
      end
      begin
        repeat (2) @(posedge dst_clk_i);
        dst_rst_ni <= 1'b1;
      end
    join

    // both sides come out of reset with a clear sequence running
    @(negedge dst_clk_i);
    check_value("dst_valid_o", dst_valid_o, 1'b0);
    follow_dst_pending(1'b0);
    follow_src_pending(1'b0);
    @(negedge src_clk_i);
    check_value("src_ready_o", src_ready_o, 1'b1);

    foreach (steps[i]) begin
      item.tag  = steps[i].tag;
      item.data = steps[i].data;
      case (steps[i].op)
        OP_SEND: begin
          drive_item(item);
          await_accept(item);
        end
        OP_BACKPRESSURE: begin
          drain_pipeline();
          run_backpressure(item);
        end
        OP_SRC_CLEAR: begin
          drain_pipeline();
          pulse_src_clear();
        end
        OP_DST_CLEAR: begin
          drain_pipeline();
          pulse_dst_clear();
        end
        default: begin
          drain_pipeline();
          pulse_src_reset();
        end
      endcase
    end

    drain_pipeline();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* hw/cdc_bridge_top.sv */
// cdc bridge top, a clearable two-phase crossing for one 32-bit payload at a time
module cdc_bridge_top import cdc_pkg::*; (
  input  logic                        src_clk_i,
  input  logic                        src_rst_ni,
  input  logic                        src_clear_i,
  input  logic                        src_valid_i,
  input  logic [$bits(payload_t)-1:0] src_data_i,
  output logic                        src_ready_o,
  output logic                        src_clear_pending_o,
  input  logic                        dst_clk_i,
  input  logic                        dst_rst_ni,
  input  logic                        dst_clear_i,
  input  logic                        dst_ready_i,
  output logic [$bits(payload_t)-1:0] dst_data_o,
  output logic                        dst_valid_o,
  output logic                        dst_clear_pending_o
);

  // the crossing itself, these three wires carry no clock
  logic     async_req;
  logic     async_ack;
  payload_t async_data;

  logic     src_valid_gated;
  logic     src_ready_raw;
  logic     dst_ready_gated;
  logic     dst_valid_raw;
  payload_t src_payload;
  payload_t dst_payload;

  cdc_clear_if i_src_clear_if ();
  cdc_clear_if i_dst_clear_if ();

  assign src_payload = payload_t'(src_data_i);

  // while isolated neither side may start or finish a handshake
  assign src_valid_gated = src_valid_i & ~i_src_clear_if.isolate_req;
  assign src_ready_o     = src_ready_raw & ~i_src_clear_if.isolate_req;

  cdc_src_half i_src_half (
    .clk_i        (src_clk_i),
    .rst_ni       (src_rst_ni),
    .clear_i      (i_src_clear_if.clear_req),
    .valid_i      (src_valid_gated),
    .data_i       (src_payload),
    .ready_o      (src_ready_raw),
    .async_req_o  (async_req),
    .async_ack_i  (async_ack),
    .async_data_o (async_data)
  );

  assign dst_ready_gated = dst_ready_i & ~i_dst_clear_if.isolate_req;
  assign dst_valid_o     = dst_valid_raw & ~i_dst_clear_if.isolate_req;

  cdc_dst_half i_dst_half (
    .clk_i        (dst_clk_i),
    .rst_ni       (dst_rst_ni),
    .clear_i      (i_dst_clear_if.clear_req),
    .ready_i      (dst_ready_gated),
    .data_o       (dst_payload),
    .valid_o      (dst_valid_raw),
    .async_req_i  (async_req),
    .async_ack_o  (async_ack),
    .async_data_i (async_data)
  );

  assign dst_data_o = dst_payload;

  // the source is side a of the sequencer, the destination side b
  cdc_clear_ctrl i_clear_ctrl (
    .a_clk_i   (src_clk_i),
    .a_rst_ni  (src_rst_ni),
    .a_clear_i (src_clear_i),
    .a_side    (i_src_clear_if),
    .b_clk_i   (dst_clk_i),
    .b_rst_ni  (dst_rst_ni),
    .b_clear_i (dst_clear_i),
    .b_side    (i_dst_clear_if)
  );

  // masking takes effect in the same cycle, so one register stage is enough
  // to answer both requests
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      i_src_clear_if.isolate_ack <= 1'b0;
      i_src_clear_if.clear_ack   <= 1'b0;
    end else begin
      i_src_clear_if.isolate_ack <= i_src_clear_if.isolate_req;
      i_src_clear_if.clear_ack   <= i_src_clear_if.clear_req;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      i_dst_clear_if.isolate_ack <= 1'b0;
      i_dst_clear_if.clear_ack   <= 1'b0;
    end else begin
      i_dst_clear_if.isolate_ack <= i_dst_clear_if.isolate_req;
      i_dst_clear_if.clear_ack   <= i_dst_clear_if.clear_req;
    end
  end

  // isolation lasts from the first request to the final release
  assign src_clear_pending_o = i_src_clear_if.isolate_req;
  assign dst_clear_pending_o = i_dst_clear_if.isolate_req;

endmodule

/* hw/cdc_clear_ctrl.sv */
// cdc clear sequencer, which walks both domains through isolate, clear and release together
`include "cdc_consts.svh"

module cdc_clear_ctrl import cdc_pkg::*; (
  input  logic      a_clk_i,
  input  logic      a_rst_ni,
  input  logic      a_clear_i,
  cdc_clear_if.ctrl a_side,
  input  logic      b_clk_i,
  input  logic      b_rst_ni,
  input  logic      b_clear_i,
  cdc_clear_if.ctrl b_side
);

  // after the peer has released, a side stays isolated this many more cycles
  // so the zeroed toggles of the peer are through the data synchronizers
  localparam int unsigned hold_w = $clog2(`CDC_SYNC_STAGES + 1);
  localparam logic [hold_w-1:0] hold_max = hold_w'(`CDC_SYNC_STAGES);

  clear_phase_e      a_phase_d;
  clear_phase_e      a_phase_q;
  clear_phase_e      b_phase_d;
  clear_phase_e      b_phase_q;
  logic [hold_w-1:0] a_hold_d;
  logic [hold_w-1:0] a_hold_q;
  logic [hold_w-1:0] b_hold_d;
  logic [hold_w-1:0] b_hold_q;
  // phase bits of each side as seen from the other domain
  logic [1:0]        b_bits_in_a;
  logic [1:0]        a_bits_in_b;
  clear_phase_e      b_seen_in_a;
  clear_phase_e      a_seen_in_b;

  // the sequencer of one side, shared by both domains
  // a side only steps once its own acknowledge is in and the peer has reached
  // the same phase or is one step ahead
  function automatic clear_phase_e next_phase(
    input clear_phase_e cur,
    input clear_phase_e peer,
    input logic         start,
    input logic         iso_ack,
    input logic         clr_ack,
    input logic         released
  );
    clear_phase_e nxt;
    nxt = cur;
    case (cur)
      PH_IDLE: begin
        // a local clear, or the peer asking to follow
        if (start || (peer inside {PH_ISOLATE, PH_CLEAR})) begin
          nxt = PH_ISOLATE;
        end
      end
      PH_ISOLATE: begin
        if (iso_ack && !clr_ack && (peer inside {PH_ISOLATE, PH_CLEAR})) begin
          nxt = PH_CLEAR;
        end
      end
      PH_CLEAR: begin
        if (clr_ack && (peer inside {PH_CLEAR, PH_POST_CLEAR})) begin
          nxt = PH_POST_CLEAR;
        end
      end
      default: begin
        // the peer was reset again before we let go, start over with it
        if (peer == PH_ISOLATE) begin
          nxt = PH_ISOLATE;
        end else if (released) begin
          nxt = PH_IDLE;
        end
      end
    endcase
    return nxt;
  endfunction

  // counts release cycles while the clear acknowledge is down and the peer
  // is done too, a short glitch of the peer view restarts the count
  function automatic logic [hold_w-1:0] next_hold(
    input clear_phase_e      cur,
    input clear_phase_e      peer,
    input logic              clr_ack,
    input logic [hold_w-1:0] hold
  );
    logic [hold_w-1:0] nxt;
    nxt = '0;
    if ((cur == PH_POST_CLEAR) && !clr_ack && (peer inside {PH_POST_CLEAR, PH_IDLE})) begin
      nxt = (hold == hold_max) ? hold : hold + 1'b1;
    end
    return nxt;
  endfunction

  // each phase bit crosses on its own, gray coding keeps the pair coherent
  // one stage shorter than the data path so that a reset side isolates its
  // peer before the peer can see a toggle that the reset threw away
  for (genvar i = 0; i < 2; i++) begin : gen_sync
    cdc_sync #(
      .stages (`CDC_SYNC_STAGES - 1)
    ) i_sync_b2a (
      .clk_i    (a_clk_i),
      .rst_ni   (a_rst_ni),
      .serial_i (b_phase_q[i]),
      .serial_o (b_bits_in_a[i])
    );

    cdc_sync #(
      .stages (`CDC_SYNC_STAGES - 1)
    ) i_sync_a2b (
      .clk_i    (b_clk_i),
      .rst_ni   (b_rst_ni),
      .serial_i (a_phase_q[i]),
      .serial_o (a_bits_in_b[i])
    );
  end

  assign b_seen_in_a = clear_phase_e'(b_bits_in_a);
  assign a_seen_in_b = clear_phase_e'(a_bits_in_b);

  always_comb begin
    a_phase_d = next_phase(a_phase_q, b_seen_in_a, a_clear_i, a_side.isolate_ack,
                           a_side.clear_ack, a_hold_q == hold_max);
    a_hold_d  = next_hold(a_phase_q, b_seen_in_a, a_side.clear_ack, a_hold_q);
    b_phase_d = next_phase(b_phase_q, a_seen_in_b, b_clear_i, b_side.isolate_ack,
                           b_side.clear_ack, b_hold_q == hold_max);
    b_hold_d  = next_hold(b_phase_q, a_seen_in_b, b_side.clear_ack, b_hold_q);
  end

  // a side leaving reset is isolated straight away and pulls the peer along
  always_ff @(posedge a_clk_i or negedge a_rst_ni) begin
    if (!a_rst_ni) begin
      a_phase_q <= PH_ISOLATE;
      a_hold_q  <= '0;
    end else begin
      a_phase_q <= a_phase_d;
      a_hold_q  <= a_hold_d;
    end
  end

  always_ff @(posedge b_clk_i or negedge b_rst_ni) begin
    if (!b_rst_ni) begin
      b_phase_q <= PH_ISOLATE;
      b_hold_q  <= '0;
    end else begin
      b_phase_q <= b_phase_d;
      b_hold_q  <= b_hold_d;
    end
  end

  // isolation spans the whole sequence, the clear only its middle phase
  assign a_side.isolate_req = (a_phase_q != PH_IDLE);
  assign a_side.clear_req   = (a_phase_q == PH_CLEAR);
  assign a_side.phase       = a_phase_q;
  assign b_side.isolate_req = (b_phase_q != PH_IDLE);
  assign b_side.clear_req   = (b_phase_q == PH_CLEAR);
  assign b_side.phase       = b_phase_q;

endmodule

/* hw/cdc_dst_half.sv */
// cdc destination half, which captures the payload on a request toggle and acknowledges it
`include "cdc_consts.svh"

module cdc_dst_half import cdc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     ready_i,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     async_req_i,
  output logic     async_ack_o,
  input  payload_t async_data_i
);

  logic     ack_d;
  logic     ack_q;
  logic     req_synced;
  logic     req_synced_q;
  payload_t data_d;
  payload_t data_q;

  // bring the request toggle of the source into this domain
  cdc_sync #(
    .stages (`CDC_SYNC_STAGES)
  ) i_sync_req (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (async_req_i),
    .serial_o (req_synced)
  );

  // the acknowledge flips once per item taken by the consumer
  always_comb begin
    ack_d = ack_q;
    if (clear_i) begin
      ack_d = 1'b0;
    end else if (valid_o && ready_i) begin
      ack_d = ~ack_q;
    end
  end

  // async_data_i is stable by the time the toggle has passed the synchronizer,
  // so it is sampled on the edge seen between req_synced and its delayed copy
  always_comb begin
    data_d = data_q;
    if ((req_synced != req_synced_q) && !valid_o) begin
      data_d = async_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      req_synced_q <= 1'b0;
    end else begin
      ack_q        <= ack_d;
      req_synced_q <= req_synced;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  // an item is waiting while the acknowledge lags the delayed request
  assign valid_o     = (ack_q != req_synced_q);
  assign data_o      = data_q;
  assign async_ack_o = ack_q;

endmodule

/* hw/cdc_src_half.sv */
// cdc source half, which toggles the request per accepted item and holds the payload
`include "cdc_consts.svh"

module cdc_src_half import cdc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     async_req_o,
  input  logic     async_ack_i,
  output payload_t async_data_o
);

  logic     req_d;
  logic     req_q;
  logic     ack_synced;
  payload_t data_d;
  payload_t data_q;

  // bring the acknowledge toggle of the destination into this domain
  cdc_sync #(
    .stages (`CDC_SYNC_STAGES)
  ) i_sync_ack (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .serial_i (async_ack_i),
    .serial_o (ack_synced)
  );

  always_comb begin
    req_d  = req_q;
    data_d = data_q;
    if (clear_i) begin
      // the destination zeroes its acknowledge in the same sequence
      req_d = 1'b0;
    end else if (valid_i && ready_o) begin
      // a new item opens a request, the payload then stays put until acknowledged
      req_d  = ~req_q;
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  // no request is open once the acknowledge toggle has caught up
  assign ready_o      = (req_q == ack_synced);
  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

/* hw/cdc_sync.sv */
// cdc synchronizer, a reset-to-zero flip-flop chain bringing one bit into clk_i
`include "cdc_consts.svh"

module cdc_sync #(
  // length of the chain, two or more
  parameter int unsigned stages = `CDC_SYNC_STAGES
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic serial_i,
  output logic serial_o
);

  // chain_q[0] is the first flop and may go metastable
  logic [stages-1:0] chain_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chain_q <= '0;
    end else begin
      chain_q <= {chain_q[stages-2:0], serial_i};
    end
  end

  // only the last flop is safe to use in the clk_i domain
  assign serial_o = chain_q[stages-1];

endmodule

/* hw/cdc_clear_if.sv */
// cdc clear interface carrying one domain's isolate and clear handshakes
interface cdc_clear_if import cdc_pkg::*; ();

  // high for the whole clear sequence, valid and ready are masked meanwhile
  logic isolate_req;

  // registered copy of isolate_req, one cycle later in the side's clock
  logic isolate_ack;

  // high while the toggle registers of this side are zeroed
  logic clear_req;

  // registered copy of clear_req
  logic clear_ack;

  // current phase of this side's sequencer, only observed
  clear_phase_e phase;

  // the sequencer raises and drops the requests
  modport ctrl (
    output isolate_req,
    output clear_req,
    output phase,
    input  isolate_ack,
    input  clear_ack
  );

  // the bridge top answers the requests
  modport side (
    input  isolate_req,
    input  clear_req,
    input  phase,
    output isolate_ack,
    output clear_ack
  );

endinterface

/* hw/cdc_pkg.sv */
// cdc package holding the payload format and the clear sequencer phases
`include "cdc_consts.svh"

package cdc_pkg;

  // one item crossing the bridge, the tag sits in the upper bits
  typedef struct packed {
    logic [`CDC_TAG_W-1:0]  tag;
    logic [`CDC_DATA_W-1:0] data;
  } payload_t;

  // phases of the clear sequence, gray coded
  // each step flips a single bit, so the two bits may cross the clock
  // boundary through separate synchronizers without a false phase
  // bit 0 acts as the request and bit 1 as the acknowledge of a
  // four-phase handshake toward the other domain
  typedef enum logic [1:0] {
    PH_IDLE       = 2'b00,
    PH_ISOLATE    = 2'b01,
    PH_CLEAR      = 2'b11,
    PH_POST_CLEAR = 2'b10
  } clear_phase_e;

endpackage

/* hw/cdc_consts.svh */
// cdc bridge constants for synchronizer depth and payload field widths
`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

// flip-flops per synchronizer on the data toggles
// the clear sequencer runs one stage shorter, so a one-sided asynchronous
// reset isolates the peer no later than the stale toggle reaches its output
// and this depth must stay at three or more
`define CDC_SYNC_STAGES 3

// payload fields, 32 bits together
`define CDC_TAG_W 4
`define CDC_DATA_W 28

`endif
